/* src/scope_params.svh */
// Scope capture front end
// Address map and widths

`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

// Bus address of register 0
`define SCOPE_BASE_ADDRESS 32'h43C0_0000

// Sample width from the ADC
`define SCOPE_DATA_WIDTH 16

// Bus address and data width
`define SCOPE_BUS_WIDTH 32

// Register byte offsets within the block
`define SCOPE_REG_PERIOD 32'h0000_0000
`define SCOPE_REG_BASE   32'h0000_0004
`define SCOPE_REG_ENABLE 32'h0000_0008

`endif

/* src/scope_pkg.sv */
// Scope shared types

`include "scope_params.svh"

`default_nettype none

package scope_pkg;

    // Bus write handling states
    typedef enum logic {
        idle = 1'b0,
        act  = 1'b1
    } control_state_t;

    // Offset within the register block and in beat address math
    typedef logic [`SCOPE_BUS_WIDTH-1:0] reg_offset_t;

endpackage

`default_nettype wire

/* src/simple_bus_if.sv */
// Simple memory-mapped bus

`include "scope_params.svh"

`default_nettype none

interface simple_bus_if;

    logic [`SCOPE_BUS_WIDTH-1:0] address;
    logic [`SCOPE_BUS_WIDTH-1:0] write_data;
    logic                        write_strobe;
    logic [`SCOPE_BUS_WIDTH-1:0] read_data;
    logic                        ready;

    modport master (
        output address,
        output write_data,
        output write_strobe,
        input  read_data,
        input  ready
    );

    modport slave (
        input  address,
        input  write_data,
        input  write_strobe,
        output read_data,
        output ready
    );

endinterface

`default_nettype wire

/* src/scope_control.sv */
// Scope control unit
// Register file behind the simple bus

`include "scope_params.svh"

`default_nettype none

module scope_control (
    input  logic                        clock,
    input  logic                        reset,
    simple_bus_if.slave                 bus,
    output logic [`SCOPE_BUS_WIDTH-1:0] frame_period,
    output logic [`SCOPE_BUS_WIDTH-1:0] buffer_base,
    output logic                        capture_enable,
    output logic [`SCOPE_BUS_WIDTH-1:0] dma_transfer_size
);

    import scope_pkg::*;

    control_state_t              state;
    logic                        act_done;
    reg_offset_t                 latched_offset;
    logic [`SCOPE_BUS_WIDTH-1:0] latched_data;
    reg_offset_t                 read_offset;

    // Capture address and data of an accepted write
    always_ff @(posedge clock) begin
        if (bus.write_strobe && bus.ready) begin
            latched_offset <= reg_offset_t'(bus.address - `SCOPE_BASE_ADDRESS);
            latched_data   <= bus.write_data;
        end
    end

    // Idle waits for a write and act applies it before releasing the bus
    always_ff @(posedge clock) begin
        if (!reset) begin
            state             <= idle;
            act_done          <= 1'b0;
            bus.ready         <= 1'b1;
            frame_period      <= '0;
            buffer_base       <= '0;
            capture_enable    <= 1'b0;
            dma_transfer_size <= '0;
        end else begin
            case (state)
                idle: begin
                    act_done <= 1'b0;
                    if (bus.write_strobe && bus.ready) begin
                        bus.ready <= 1'b0;
                        state     <= act;
                    end
                end
                act: begin
                    if (act_done) begin
                        // Register already updated so hand the bus back
                        act_done  <= 1'b0;
                        bus.ready <= 1'b1;
                        state     <= idle;
                    end else begin
                        act_done <= 1'b1;
                        case (latched_offset)
                            `SCOPE_REG_PERIOD: begin
                                frame_period      <= latched_data;
                                // Four bytes per beat
                                dma_transfer_size <= latched_data << 2;
                            end
                            `SCOPE_REG_BASE: begin
                                buffer_base <= latched_data;
                            end
                            `SCOPE_REG_ENABLE: begin
                                capture_enable <= latched_data[0];
                            end
                            default: begin
                                // Unmapped offsets are dropped
                            end
                        endcase
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Readback follows the address with no strobe
    always_comb begin
        read_offset = reg_offset_t'(bus.address - `SCOPE_BASE_ADDRESS);
        case (read_offset)
            `SCOPE_REG_PERIOD: bus.read_data = frame_period;
            `SCOPE_REG_BASE:   bus.read_data = buffer_base;
            `SCOPE_REG_ENABLE: bus.read_data = {{(`SCOPE_BUS_WIDTH-1){1'b0}}, capture_enable};
            default:           bus.read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/capture_framer.sv */
// Capture framer
// ADC samples to DMA write beats

`include "scope_params.svh"

`default_nettype none

module capture_framer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`SCOPE_BUS_WIDTH-1:0] frame_period,
    input  logic [`SCOPE_BUS_WIDTH-1:0] buffer_base,
    input  logic                        capture_enable,
    input  logic [`SCOPE_DATA_WIDTH-1:0] sample_data,
    input  logic                        sample_valid,
    output logic                        dma_valid,
    output logic [`SCOPE_BUS_WIDTH-1:0] dma_address,
    output logic [`SCOPE_DATA_WIDTH-1:0] dma_data,
    output logic                        dma_last
);

    import scope_pkg::*;

    reg_offset_t frame_index;
    logic        frame_end;
    logic        beat_valid;
    logic        beat_last;

    // Last beat of a frame
    // Periods of 0 and 1 end every beat
    always_comb begin
        if (frame_period <= 1) begin
            frame_end = 1'b1;
        end else begin
            frame_end = (frame_index >= frame_period - 1);
        end
    end

    // Sample index within the current frame
    always_ff @(posedge clock) begin
        if (!reset) begin
            frame_index <= '0;
        end else if (!capture_enable) begin
            frame_index <= '0;
        end else if (sample_valid) begin
            frame_index <= frame_end ? reg_offset_t'(0) : frame_index + 1;
        end
    end

    // Beat control
    always_ff @(posedge clock) begin
        if (!reset) begin
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
        end else begin
            beat_valid <= capture_enable && sample_valid;
            beat_last  <= capture_enable && sample_valid && frame_end;
        end
    end

    // Beat payload
    always_ff @(posedge clock) begin
        if (sample_valid) begin
            dma_data    <= sample_data;
            dma_address <= buffer_base + (frame_index << 2);
        end
    end

    // A beat still in flight when capture is switched off is dropped
    assign dma_valid = beat_valid && capture_enable;
    assign dma_last  = beat_last && capture_enable;

endmodule

`default_nettype wire

/* src/scope_top.sv */
// Scope capture front end top

`include "scope_params.svh"

`default_nettype none

module scope_top (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [`SCOPE_BUS_WIDTH-1:0]  bus_address,
    input  logic [`SCOPE_BUS_WIDTH-1:0]  bus_write_data,
    input  logic                         bus_write_strobe,
    output logic [`SCOPE_BUS_WIDTH-1:0]  bus_read_data,
    output logic                         bus_ready,
    input  logic [`SCOPE_DATA_WIDTH-1:0] sample_data,
    input  logic                         sample_valid,
    output logic                         dma_valid,
    output logic [`SCOPE_BUS_WIDTH-1:0]  dma_address,
    output logic [`SCOPE_DATA_WIDTH-1:0] dma_data,
    output logic                         dma_last,
    output logic [`SCOPE_BUS_WIDTH-1:0]  dma_transfer_size
);

    logic [`SCOPE_BUS_WIDTH-1:0] frame_period;
    logic [`SCOPE_BUS_WIDTH-1:0] buffer_base;
    logic                        capture_enable;

    simple_bus_if bus ();

    // Master side comes straight from the pins
    assign bus.address      = bus_address;
    assign bus.write_data   = bus_write_data;
    assign bus.write_strobe = bus_write_strobe;
    assign bus_read_data    = bus.read_data;
    assign bus_ready        = bus.ready;

    scope_control i_control (
        .clock             (clock),
        .reset             (reset),
        .bus               (bus.slave),
        .frame_period      (frame_period),
        .buffer_base       (buffer_base),
        .capture_enable    (capture_enable),
        .dma_transfer_size (dma_transfer_size)
    );

    capture_framer i_framer (
        .clock          (clock),
        .reset          (reset),
        .frame_period   (frame_period),
        .buffer_base    (buffer_base),
        .capture_enable (capture_enable),
        .sample_data    (sample_data),
        .sample_valid   (sample_valid),
        .dma_valid      (dma_valid),
        .dma_address    (dma_address),
        .dma_data       (dma_data),
        .dma_last       (dma_last)
    );

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
// Testbench clock source

`default_nettype none

module clock_gen #(
    parameter int period = 100
) (
    output logic clock
);

    initial clock = 1'b0;

    always #(period / 2) clock = ~clock;

endmodule

`default_nettype wire

/* tb/scope_props.sv */
// Bus handshake and framer assertions

`default_nettype none

module scope_props (
    input logic clock,
    input logic reset,
    input logic write_strobe,
    input logic ready,
    input logic capture_enable,
    input logic dma_valid,
    input logic dma_last
);

    logic accepted;

    assign accepted = write_strobe && ready;

    // Ready only drops after a write taken while it was high
    ready_drop: assert property (@(posedge clock) disable iff (!reset)
        $fell(ready) |-> $past(accepted))
        else $error("ready fell without an accepted write");

    // Two busy cycles and then the bus is free again
    ready_busy: assert property (@(posedge clock) disable iff (!reset)
        ($past(accepted) || $past(accepted, 2)) |-> !ready)
        else $error("ready high too early after a write");

    ready_back: assert property (@(posedge clock) disable iff (!reset)
        $past(accepted, 3) |-> ready)
        else $error("ready still low three cycles after a write");

    last_in_beat: assert property (@(posedge clock) disable iff (!reset)
        dma_last |-> dma_valid)
        else $error("dma_last without dma_valid");

    quiet_when_off: assert property (@(posedge clock) disable iff (!reset)
        !capture_enable |-> !dma_valid)
        else $error("dma_valid while capture is disabled");

endmodule

// Watches the bus pins and the framer outputs
bind scope_top scope_props i_props (
    .clock          (clock),
    .reset          (reset),
    .write_strobe   (bus_write_strobe),
    .ready          (bus_ready),
    .capture_enable (capture_enable),
    .dma_valid      (dma_valid),
    .dma_last       (dma_last)
);

`default_nettype wire

/* tb/scope_tb.sv */
// Scope front end testbench

`include "scope_params.svh"

`default_nettype none

module scope_tb;

    localparam int op_write = 0;
    localparam int op_busy  = 1;
    localparam int op_read  = 2;
    localparam int op_burst = 3;
    localparam int op_idle  = 4;
    localparam int max_rows = 40;

    logic                         clock;
    logic                         reset;
    logic [`SCOPE_BUS_WIDTH-1:0]  bus_address;
    logic [`SCOPE_BUS_WIDTH-1:0]  bus_write_data;
    logic                         bus_write_strobe;
    logic [`SCOPE_BUS_WIDTH-1:0]  bus_read_data;
    logic                         bus_ready;
    logic [`SCOPE_DATA_WIDTH-1:0] sample_data;
    logic                         sample_valid;
    logic                         dma_valid;
    logic [`SCOPE_BUS_WIDTH-1:0]  dma_address;
    logic [`SCOPE_DATA_WIDTH-1:0] dma_data;
    logic                         dma_last;
    logic [`SCOPE_BUS_WIDTH-1:0]  dma_transfer_size;

    // One operation per row in the stimulus table
    int          row_op [max_rows];
    int          row_test [max_rows];
    logic [31:0] row_a [max_rows];
    logic [31:0] row_b [max_rows];
    logic [31:0] row_c [max_rows];
    int          row_total = 0;
    int          watchdog_cycles = 54;
    logic        table_ready = 1'b0;
    string       test_name [5] = '{"reset state", "register access", "busy write",
                                   "framing", "enable restart"};

    // Reference model
    logic [31:0] shadow_period;
    logic [31:0] shadow_base;
    logic        shadow_enable;
    logic [31:0] model_index;
    logic [31:0] lcg_state;
    int          check_count;
    int          error_count;
    int          test_start_errors;

    clock_gen #(.period(100)) i_clock (.clock(clock));

    scope_top i_dut (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input int op, input int test, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] c);
        row_op[row_total]   = op;
        row_test[row_total] = test;
        row_a[row_total]    = a;
        row_b[row_total]    = b;
        row_c[row_total]    = c;
        row_total++;
        case (op)
            op_write: watchdog_cycles += 4;
            op_busy:  watchdog_cycles += 5;
            op_read:  watchdog_cycles += 1;
            op_burst: watchdog_cycles += int'(a) + 2;
            default:  watchdog_cycles += int'(a);
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic bus_write(input logic [31:0] offset, input logic [31:0] data,
                             input logic busy, input logic [31:0] ignored);
        while (!bus_ready) @(negedge clock);
        bus_address      = `SCOPE_BASE_ADDRESS + offset;
        bus_write_data   = data;
        bus_write_strobe = 1'b1;
        @(negedge clock);
        // Second strobe lands while the bus is busy
        if (busy) begin
            check_value("bus_ready", 32'd0, 32'(bus_ready));
            bus_write_data = ignored;
            @(negedge clock);
        end
        bus_write_strobe = 1'b0;
        while (!bus_ready) @(negedge clock);
        case (offset)
            `SCOPE_REG_PERIOD: shadow_period = data;
            `SCOPE_REG_BASE:   shadow_base = data;
            `SCOPE_REG_ENABLE: shadow_enable = data[0];
            default: ;
        endcase
        if (!shadow_enable) model_index = '0;
        check_value("dma_transfer_size", shadow_period * 4, dma_transfer_size);
    endtask

    task automatic bus_read(input logic [31:0] offset, input logic [31:0] expected);
        bus_address = `SCOPE_BASE_ADDRESS + offset;
        @(negedge clock);
        check_value("bus_read_data", expected, bus_read_data);
    endtask

    // Each beat is checked one cycle after its sample went in
    task automatic sample_burst(input int count, input logic enabled);
        int                           i;
        logic                         pending;
        logic                         beat_last;
        logic [`SCOPE_DATA_WIDTH-1:0] sent;
        pending = 1'b0;
        sent    = '0;
        for (i = 0; i <= count; i++) begin
            if (pending && enabled) begin
                beat_last = (shadow_period <= 1) || (model_index == shadow_period - 1);
                check_value("dma_valid", 32'd1, 32'(dma_valid));
                check_value("dma_data", 32'(sent), 32'(dma_data));
                check_value("dma_address", shadow_base + 4 * model_index, dma_address);
                check_value("dma_last", 32'(beat_last), 32'(dma_last));
                model_index = beat_last ? 32'd0 : model_index + 1;
            end else if (pending) begin
                check_value("dma_valid", 32'd0, 32'(dma_valid));
                model_index = '0;
            end
            if (i < count) begin
                lcg_state    = lcg_next(lcg_state);
                sent         = lcg_state[31:16];
                sample_data  = sent;
                sample_valid = 1'b1;
                pending      = 1'b1;
            end else begin
                sample_valid = 1'b0;
            end
            @(negedge clock);
        end
        check_value("dma_valid", 32'd0, 32'(dma_valid));
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(negedge clock);
            check_value("dma_valid", 32'd0, 32'(dma_valid));
        end
    endtask

    task automatic report_test(input int t);
        if (error_count == test_start_errors) begin
            $display("test %0d %s: ok", t, test_name[t - 1]);
        end else begin
            $display("test %0d %s: %0d errors", t, test_name[t - 1],
                     error_count - test_start_errors);
        end
    endtask

    task automatic build_table();
        add_row(op_read,  1, `SCOPE_REG_PERIOD, 32'd0, 32'd0);
        add_row(op_read,  1, `SCOPE_REG_BASE, 32'd0, 32'd0);
        add_row(op_read,  1, `SCOPE_REG_ENABLE, 32'd0, 32'd0);
        add_row(op_idle,  1, 32'd2, 32'd0, 32'd0);
        add_row(op_write, 2, `SCOPE_REG_PERIOD, 32'd7, 32'd0);
        add_row(op_read,  2, `SCOPE_REG_PERIOD, 32'd7, 32'd0);
        add_row(op_write, 2, `SCOPE_REG_BASE, 32'h8000_1000, 32'd0);
        add_row(op_read,  2, `SCOPE_REG_BASE, 32'h8000_1000, 32'd0);
        add_row(op_write, 2, `SCOPE_REG_ENABLE, 32'd1, 32'd0);
        add_row(op_read,  2, `SCOPE_REG_ENABLE, 32'd1, 32'd0);
        add_row(op_read,  2, 32'h0000_0010, 32'd0, 32'd0);
        add_row(op_busy,  3, `SCOPE_REG_PERIOD, 32'd4, 32'h0000_dead);
        add_row(op_read,  3, `SCOPE_REG_PERIOD, 32'd4, 32'd0);
        add_row(op_busy,  3, `SCOPE_REG_BASE, 32'h0000_2000, 32'hffff_0000);
        add_row(op_read,  3, `SCOPE_REG_BASE, 32'h0000_2000, 32'd0);
        add_row(op_burst, 4, 32'd10, 32'd1, 32'd0);
        add_row(op_write, 4, `SCOPE_REG_PERIOD, 32'd1, 32'd0);
        add_row(op_burst, 4, 32'd3, 32'd1, 32'd0);
        add_row(op_write, 5, `SCOPE_REG_PERIOD, 32'd3, 32'd0);
        add_row(op_burst, 5, 32'd2, 32'd1, 32'd0);
        add_row(op_write, 5, `SCOPE_REG_ENABLE, 32'd0, 32'd0);
        add_row(op_burst, 5, 32'd4, 32'd0, 32'd0);
        add_row(op_idle,  5, 32'd2, 32'd0, 32'd0);
        add_row(op_write, 5, `SCOPE_REG_ENABLE, 32'd1, 32'd0);
        add_row(op_burst, 5, 32'd5, 32'd1, 32'd0);
        add_row(op_read,  5, `SCOPE_REG_ENABLE, 32'd1, 32'd0);
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_cycles * 100);
        $display("Timeout: the stimulus table did not finish in %0d cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int r;
        reset            = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_strobe = 1'b0;
        sample_data      = '0;
        sample_valid     = 1'b0;
        shadow_period    = '0;
        shadow_base      = '0;
        shadow_enable    = 1'b0;
        model_index      = '0;
        lcg_state        = 32'h2662_b9c2;
        check_count      = 0;
        error_count      = 0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(negedge clock);
        reset = 1'b1;
        check_value("bus_ready", 32'd1, 32'(bus_ready));
        check_value("dma_valid", 32'd0, 32'(dma_valid));
        test_start_errors = 0;
        for (r = 0; r < row_total; r++) begin
            if (r > 0 && row_test[r] != row_test[r - 1]) begin
                report_test(row_test[r - 1]);
                test_start_errors = error_count;
            end
            case (row_op[r])
                op_write: bus_write(row_a[r], row_b[r], 1'b0, 32'd0);
                op_busy:  bus_write(row_a[r], row_b[r], 1'b1, row_c[r]);
                op_read:  bus_read(row_a[r], row_b[r]);
                op_burst: sample_burst(int'(row_a[r]), row_b[r][0]);
                default:  idle_cycles(int'(row_a[r]));
            endcase
        end
        report_test(row_test[row_total - 1]);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/scope_pkg.sv
src/simple_bus_if.sv
src/scope_control.sv
src/capture_framer.sv
src/scope_top.sv
tb/clock_gen.sv
tb/scope_props.sv
tb/scope_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scope testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module scope_tb

output=$(./obj_dir/Vscope_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
